// File: Makefile
TOP = tb_csi2_stat_top

sim:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f list.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF "** PASS **" sim.log

clean:
	rm -rf obj_dir sim.log

// File: list.f
+incdir+verilog
verilog/csi2_csr_pkg.sv
verilog/csi2_err_counter.sv
verilog/csi2_geom_tracker.sv
verilog/csi2_csr.sv
verilog/csi2_stat_top.sv
tests/tb_csi2_stat_top.sv

// File: tests/tb_csi2_stat_top.sv
`timescale 1ns/1ps

module tb_csi2_stat_top;

  // The whole run stays under 5000 cycles and spends most of them on frames.
  localparam int CYCLE_LIMIT = 20000;

  logic                     clk_i = 1'b0;
  logic                     srst_i;
  csi2_csr_pkg::axil_req_t  req;
  csi2_csr_pkg::axil_rsp_t  rsp;
  csi2_csr_pkg::pkt_evt_t   pkt_evt;
  csi2_csr_pkg::frame_evt_t frame_evt;
  logic                     phy_en;
  logic [6:0]               sccb_addr;
  logic [4:0]               lane_0_delay;
  logic [4:0]               lane_1_delay;
  logic                     delay_act;

  logic [15:0] lfsr = 16'd20601;
  logic [31:0] cr_m [6];   // Control words.
  logic [31:0] stat_m [7]; // Status words 6 to 12.
  int          cycle_cnt = 0;
  int          check_cnt = 0;
  int          err_cnt = 0;
  int          err_mark = 0;
  string       reg_names [13] = '{"CLEAR_STAT", "PHY_ENABLE", "SCCB_SLAVE_ADDR", "LANE_0_DELAY",
    "LANE_1_DELAY", "DELAY_ACT", "HEADER_ERR_CNT", "CORR_HEADER_ERR_CNT", "CRC_ERR_CNT",
    "MAX_LN", "MIN_LN", "MAX_PX", "MIN_PX"};

  csi2_stat_top csi2_stat_top_i (
    .clk_i             (clk_i),
    .srst_i            (srst_i),
    .axil_req_i        (req),
    .axil_rsp_o        (rsp),
    .pkt_evt_i         (pkt_evt),
    .frame_evt_i       (frame_evt),
    .phy_en_o          (phy_en),
    .sccb_slave_addr_o (sccb_addr),
    .lane_0_delay_o    (lane_0_delay),
    .lane_1_delay_o    (lane_1_delay),
    .delay_act_o       (delay_act)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i)
    begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == CYCLE_LIMIT)
        begin
          $display("Timeout, the run did not end within %0d cycles.", cycle_cnt);
          $display("** FAIL **");
          $finish;
        end
    end

  // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic next_bit();
    logic out;
    out  = lfsr[0];
    lfsr = (lfsr >> 1) ^ (out ? 16'hB400 : 16'h0000);
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], next_bit()};
    return v;
  endfunction

  function automatic logic [31:0] expect_word(int w);
    if (w < 6)
      return cr_m[w];
    if (w < 13)
      return stat_m[w-6];
    return '0; // Unmapped.
  endfunction

  function automatic void clear_model();
    stat_m = '{0, 0, 0, 0, 32'hffff_ffff, 0, 32'hffff_ffff};
  endfunction

  // The minimum of each pair sits right after its maximum.
  function automatic void fold(int idx, logic [31:0] v);
    if (v > stat_m[idx])
      stat_m[idx] = v;
    if (v < stat_m[idx+1])
      stat_m[idx+1] = v;
  endfunction

  task automatic check_val(string name, logic [31:0] exp, logic [31:0] got);
    check_cnt++;
    if (got !== exp)
      begin
        $display("ERR %s: expected %h, got %h", name, exp, got);
        err_cnt++;
      end
  endtask

  task automatic axil_xfer(logic wr, logic [7:0] addr, logic [31:0] wdata, logic [3:0] strb,
                           output logic [31:0] rdata);
    int lat;
    req = '{awvalid: wr, awaddr: addr, wvalid: wr, wdata: wdata, wstrb: strb,
            arvalid: !wr, araddr: addr};
    @(negedge clk_i);
    req = '0;
    lat = 1;
    while (!(wr ? rsp.bvalid : rsp.rvalid))
      begin
        @(negedge clk_i);
        lat++;
      end
    rdata = rsp.rdata;
    if (lat != 1)
      begin
        $display("Response came %0d cycles after the request instead of 1.", lat);
        err_cnt++;
      end
    if (wr)
      check_val("bresp", 32'h0, 32'(rsp.bresp));
    else
      check_val("rresp", 32'h0, 32'(rsp.rresp));
    check_val("awready/wready/arready", 32'h7, 32'({rsp.awready, rsp.wready, rsp.arready}));
  endtask

  task automatic write_reg(logic [7:0] addr, logic [31:0] data, logic [3:0] strb);
    logic [31:0] old;
    logic [31:0] dummy;
    int          w;
    w = addr >> 2;
    if (w < 6)
      begin
        old = cr_m[w];
        for (int b = 0; b < 4; b++)
          if (strb[b])
            cr_m[w][b*8 +: 8] = data[b*8 +: 8];
        if ((w == 0) && !old[0] && cr_m[0][0])
          clear_model(); // Rising bit 0 of CLEAR_STAT.
      end
    axil_xfer(1'b1, addr, data, strb, dummy);
  endtask

  task automatic check_addr(logic [7:0] addr);
    logic [31:0] data;
    int          w;
    w = addr >> 2;
    axil_xfer(1'b0, addr, '0, '0, data);
    check_val((w < 13) ? reg_names[w] : $sformatf("word %0d", w), expect_word(w), data);
  endtask

  task automatic check_status();
    for (int w = 6; w < 13; w++)
      check_addr(8'(w * 4));
  endtask

  task automatic run_strobes(int n);
    logic [2:0] s;
    for (int i = 0; i < n; i++)
      begin
        s       = 3'(rand_bits(3));
        pkt_evt = s;
        for (int b = 0; b < 3; b++)
          if (s[2-b] && (stat_m[b] != 32'hffff_ffff))
            stat_m[b]++;
        @(negedge clk_i);
      end
    pkt_evt = '0;
  endtask

  task automatic evt_cycle(logic [4:0] e);
    frame_evt = e;
    @(negedge clk_i);
    frame_evt = '0;
  endtask

  // Markers are {frame_start, frame_end, line_start, line_end, px_valid}.
  task automatic run_frame();
    int   n_ln;
    int   n_px;
    int   len;
    logic px;
    n_ln = rand_bits(3);
    evt_cycle(5'(rand_bits(4))); // Strays while idle.
    evt_cycle(5'b10000);
    for (int l = 0; l < n_ln; l++)
      begin
        if (rand_bits(2) == 0)
          evt_cycle(rand_bits(1) ? 5'b00010 : 5'b10000); // Strays between lines.
        evt_cycle(5'b00100);
        n_px = 0;
        len  = rand_bits(4);
        for (int c = 0; c < len; c++)
          begin
            px   = rand_bits(1);
            n_px = n_px + px;
            evt_cycle({4'b0000, px});
          end
        evt_cycle(5'b00010);
        fold(5, n_px);
      end
    evt_cycle(5'b01000);
    fold(3, n_ln);
    repeat (2) evt_cycle('0); // Folding lags the end marker.
  endtask

  task automatic end_test(string name);
    $display("Test %s: %s", name, (err_cnt == err_mark) ? "ok" : "failed");
    err_mark = err_cnt;
  endtask

  initial
    begin
      logic [7:0]  addr;
      logic [31:0] data;
      logic [3:0]  strb;
      srst_i    = 1'b1;
      req       = '0;
      pkt_evt   = '0;
      frame_evt = '0;
      cr_m      = '{default: '0};
      clear_model();
      repeat (2) @(negedge clk_i);
      srst_i = 1'b0;

      for (int w = 0; w < 16; w++)
        check_addr(8'(w * 4));
      check_val("control outputs", '0,
                32'({phy_en, sccb_addr, lane_0_delay, lane_1_delay, delay_act}));
      end_test("1 after reset");

      for (int i = 0; i < 60; i++)
        begin
          if (rand_bits(1))
            addr = 8'(rand_bits(8)); // Mostly status and unmapped words.
          else
            addr = 8'((rand_bits(3) % 6) * 4);
          data = rand_bits(32);
          strb = 4'(rand_bits(4));
          write_reg(addr, data, strb);
          check_addr(addr);
          check_val("phy outputs", 32'({cr_m[1][0], cr_m[2][6:0], cr_m[3][4:0], cr_m[4][4:0]}),
                    32'({phy_en, sccb_addr, lane_0_delay, lane_1_delay}));
        end
      for (int w = 0; w < 6; w++)
        check_addr(8'(w * 4));
      end_test("2 control writes");

      run_strobes(500);
      for (int w = 6; w < 9; w++)
        check_addr(8'(w * 4));
      end_test("3 error strobes");

      for (int f = 0; f < 24; f++)
        begin
          run_frame();
          for (int w = 9; w < 13; w++)
            check_addr(8'(w * 4));
        end
      end_test("4 frames");

      write_reg(8'h00, 32'h0, 4'hf);
      write_reg(8'h00, 32'h1, 4'hf);
      @(negedge clk_i); // Clear lands at the end of the pulse cycle.
      check_status();
      run_strobes(40);
      run_frame();
      write_reg(8'h00, 32'h1, 4'hf);
      @(negedge clk_i);
      check_status();
      end_test("5 clear statistics");

      write_reg(8'h14, 32'h0, 4'h1);
      check_val("delay_act_o", 32'h0, 32'(delay_act));
      write_reg(8'h14, 32'h1, 4'h1);
      check_val("delay_act_o", 32'h1, 32'(delay_act));
      repeat (3)
        begin
          @(negedge clk_i);
          check_val("delay_act_o", 32'h0, 32'(delay_act));
        end
      write_reg(8'h14, 32'h1, 4'h1);
      check_val("delay_act_o", 32'h0, 32'(delay_act));
      end_test("6 delay activate");

      $display("%0d checks, %0d errors", check_cnt, err_cnt);
      if (err_cnt == 0)
        $display("** PASS **");
      else
        $display("** FAIL **");
      $finish;
    end

endmodule

// File: verilog/csi2_csr.sv
`timescale 1ns/1ps
`include "csi2_csr_consts.svh"

module csi2_csr #(
  parameter int DATA_WIDTH = `CSR_DATA_W
)(
  input                             clk_i,
  input                             srst_i,
  input  csi2_csr_pkg::axil_req_t   axil_req_i,
  output csi2_csr_pkg::axil_rsp_t   axil_rsp_o,
  input  csi2_csr_pkg::err_stats_t  err_stats_i,
  input  csi2_csr_pkg::geom_stats_t geom_stats_i,
  output logic                      clear_stat_o,
  output logic                      phy_en_o,
  output logic [6:0]                sccb_slave_addr_o,
  output logic [4:0]                lane_0_delay_o,
  output logic [4:0]                lane_1_delay_o,
  output logic                      delay_act_o
);

  localparam int DATA_BYTES     = DATA_WIDTH / 8;
  localparam int ADDR_WORD_BITS = $clog2(DATA_BYTES);
  localparam int REG_IDX_W      = $clog2(`REGS_CNT);

  logic [`CR_CNT-1:0][DATA_WIDTH-1:0]   cr_q;
  logic [`REGS_CNT-1:0][DATA_WIDTH-1:0] regs;

  logic                   wr_en;
  logic [`CSR_ADDR_W-1:0] aw_word;
  logic [`CSR_ADDR_W-1:0] ar_word;
  logic                   bvalid_q;
  logic                   rvalid_q;
  logic [DATA_WIDTH-1:0]  rdata_q;
  logic                   clear_stat_d_q;
  logic                   delay_act_d_q;

  assign wr_en   = axil_req_i.awvalid && axil_req_i.wvalid;
  assign aw_word = axil_req_i.awaddr >> ADDR_WORD_BITS;
  assign ar_word = axil_req_i.araddr >> ADDR_WORD_BITS;

  // No back-pressure and every response is OKAY.
  always_comb
    begin
      axil_rsp_o.awready = 1'b1;
      axil_rsp_o.wready  = 1'b1;
      axil_rsp_o.bvalid  = bvalid_q;
      axil_rsp_o.bresp   = 2'b00;
      axil_rsp_o.arready = 1'b1;
      axil_rsp_o.rvalid  = rvalid_q;
      axil_rsp_o.rdata   = `CSR_DATA_W'(rdata_q);
      axil_rsp_o.rresp   = 2'b00;
    end

  always_ff @(posedge clk_i, posedge srst_i)
    if (srst_i)
      begin
        bvalid_q <= 1'b0;
        rvalid_q <= 1'b0;
      end
    else
      begin
        bvalid_q <= wr_en;
        rvalid_q <= axil_req_i.arvalid;
      end

  // Byte-strobed control writes. Status and unmapped words are dropped.
  always_ff @(posedge clk_i, posedge srst_i)
    if (srst_i)
      cr_q <= '0;
    else
      for (int i = 0; i < `CR_CNT; i++)
        if (wr_en && (aw_word == `CSR_ADDR_W'(i)))
          for (int j = 0; j < DATA_BYTES; j++)
            if (axil_req_i.wstrb[j])
              cr_q[i][j*8 +: 8] <= axil_req_i.wdata[j*8 +: 8];

  always_comb
    begin
      regs[`CR_CNT-1:0] = cr_q;
      regs[csi2_csr_pkg::HEADER_ERR_CNT]      = DATA_WIDTH'(err_stats_i.hdr_err_cnt);
      regs[csi2_csr_pkg::CORR_HEADER_ERR_CNT] = DATA_WIDTH'(err_stats_i.corr_hdr_err_cnt);
      regs[csi2_csr_pkg::CRC_ERR_CNT]         = DATA_WIDTH'(err_stats_i.crc_err_cnt);
      regs[csi2_csr_pkg::MAX_LN]              = DATA_WIDTH'(geom_stats_i.max_ln);
      regs[csi2_csr_pkg::MIN_LN]              = DATA_WIDTH'(geom_stats_i.min_ln);
      regs[csi2_csr_pkg::MAX_PX]              = DATA_WIDTH'(geom_stats_i.max_px);
      regs[csi2_csr_pkg::MIN_PX]              = DATA_WIDTH'(geom_stats_i.min_px);
    end

  always_ff @(posedge clk_i)
    if (axil_req_i.arvalid)
      begin
        if (ar_word < `CSR_ADDR_W'(`REGS_CNT))
          rdata_q <= regs[ar_word[REG_IDX_W-1:0]];
        else
          rdata_q <= '0; // Unmapped.
      end

  // Rising edge of bit 0 gives a one-cycle pulse.
  always_ff @(posedge clk_i, posedge srst_i)
    if (srst_i)
      begin
        clear_stat_d_q <= 1'b0;
        delay_act_d_q  <= 1'b0;
      end
    else
      begin
        clear_stat_d_q <= cr_q[csi2_csr_pkg::CLEAR_STAT][0];
        delay_act_d_q  <= cr_q[csi2_csr_pkg::DELAY_ACT][0];
      end

  assign clear_stat_o      = cr_q[csi2_csr_pkg::CLEAR_STAT][0] && !clear_stat_d_q;
  assign delay_act_o       = cr_q[csi2_csr_pkg::DELAY_ACT][0] && !delay_act_d_q;
  assign phy_en_o          = cr_q[csi2_csr_pkg::PHY_ENABLE][0];
  assign sccb_slave_addr_o = cr_q[csi2_csr_pkg::SCCB_SLAVE_ADDR][6:0];
  assign lane_0_delay_o    = cr_q[csi2_csr_pkg::LANE_0_DELAY][4:0];
  assign lane_1_delay_o    = cr_q[csi2_csr_pkg::LANE_1_DELAY][4:0];

  a_bvalid: assert property (
    @(posedge clk_i) disable iff (srst_i)
    wr_en |=> axil_rsp_o.bvalid
  )
    else $error("bvalid missing after write");

  a_rvalid: assert property (
    @(posedge clk_i) disable iff (srst_i)
    axil_req_i.arvalid |=> axil_rsp_o.rvalid
  )
    else $error("rvalid missing after read");

endmodule

// File: verilog/csi2_csr_consts.svh
`ifndef CSI2_CSR_CONSTS_SVH
`define CSI2_CSR_CONSTS_SVH

// AXI-Lite data and byte address widths.
`define CSR_DATA_W 32
`define CSR_ADDR_W 8

// Width of every counter and statistic.
`define STAT_CNT_W 32

// Control words start at word 0 and status words follow them.
`define CR_CNT     6
`define REGS_CNT   13

`endif

// File: verilog/csi2_csr_pkg.sv
`include "csi2_csr_consts.svh"

package csi2_csr_pkg;

  typedef struct packed {
    logic                     awvalid;
    logic [`CSR_ADDR_W-1:0]   awaddr;
    logic                     wvalid;
    logic [`CSR_DATA_W-1:0]   wdata;
    logic [`CSR_DATA_W/8-1:0] wstrb;
    logic                     arvalid;
    logic [`CSR_ADDR_W-1:0]   araddr;
  } axil_req_t;

  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    logic [1:0]             bresp;
    logic                   arready;
    logic                   rvalid;
    logic [`CSR_DATA_W-1:0] rdata;
    logic [1:0]             rresp;
  } axil_rsp_t;

  // Strobes from the packet decoder.
  typedef struct packed {
    logic hdr_err;
    logic corr_hdr_err;
    logic crc_err;
  } pkt_evt_t;

  typedef struct packed {
    logic frame_start;
    logic frame_end;
    logic line_start;
    logic line_end;
    logic px_valid;
  } frame_evt_t;

  typedef struct packed {
    logic [`STAT_CNT_W-1:0] hdr_err_cnt;
    logic [`STAT_CNT_W-1:0] corr_hdr_err_cnt;
    logic [`STAT_CNT_W-1:0] crc_err_cnt;
  } err_stats_t;

  typedef struct packed {
    logic [`STAT_CNT_W-1:0] max_ln;
    logic [`STAT_CNT_W-1:0] min_ln;
    logic [`STAT_CNT_W-1:0] max_px;
    logic [`STAT_CNT_W-1:0] min_px;
  } geom_stats_t;

  // Word indices are byte addresses divided by 4.
  typedef enum logic [`CSR_ADDR_W-3:0] {
    CLEAR_STAT      = 0,
    PHY_ENABLE      = 1,
    SCCB_SLAVE_ADDR = 2,
    LANE_0_DELAY    = 3,
    LANE_1_DELAY    = 4,
    DELAY_ACT       = 5
  } cr_idx_e;

  typedef enum logic [`CSR_ADDR_W-3:0] {
    HEADER_ERR_CNT      = 6,
    CORR_HEADER_ERR_CNT = 7,
    CRC_ERR_CNT         = 8,
    MAX_LN              = 9,
    MIN_LN              = 10,
    MAX_PX              = 11,
    MIN_PX              = 12
  } sr_idx_e;

  typedef enum logic [1:0] {
    IDLE,
    IN_FRAME,
    IN_LINE
  } geom_state_e;

endpackage

// File: verilog/csi2_err_counter.sv
`timescale 1ns/1ps
`include "csi2_csr_consts.svh"

module csi2_err_counter (
  input                           clk_i,
  input                           srst_i,
  input                           clear_stat_i,
  input  csi2_csr_pkg::pkt_evt_t  pkt_evt_i,
  output csi2_csr_pkg::err_stats_t err_stats_o
);

  logic [2:0]                   evt;
  logic [2:0][`STAT_CNT_W-1:0] cnt_q;

  // Bit order matches the counter order below.
  assign evt = {pkt_evt_i.crc_err, pkt_evt_i.corr_hdr_err, pkt_evt_i.hdr_err};

  always_ff @(posedge clk_i, posedge srst_i)
    if (srst_i)
      cnt_q <= '0;
    else
      if (clear_stat_i)
        cnt_q <= '0; // Clear wins over strobes.
      else
        for (int i = 0; i < 3; i++)
          if (evt[i] && (cnt_q[i] != '1))
            cnt_q[i] <= cnt_q[i] + 1'b1;

  assign err_stats_o.hdr_err_cnt      = cnt_q[0];
  assign err_stats_o.corr_hdr_err_cnt = cnt_q[1];
  assign err_stats_o.crc_err_cnt      = cnt_q[2];

  // A full counter only goes back to zero through a clear.
  for (genvar g = 0; g < 3; g++)
    begin : g_sat_chk
      a_no_wrap: assert property (
        @(posedge clk_i) disable iff (srst_i)
        ((cnt_q[g] == '1) && !clear_stat_i) |=> (cnt_q[g] != '0)
      )
        else $error("error counter %0d wrapped", g);
    end

endmodule

// File: verilog/csi2_geom_tracker.sv
`timescale 1ns/1ps
`include "csi2_csr_consts.svh"

module csi2_geom_tracker (
  input                             clk_i,
  input                             srst_i,
  input                             clear_stat_i,
  input  csi2_csr_pkg::frame_evt_t  frame_evt_i,
  output csi2_csr_pkg::geom_stats_t geom_stats_o
);

  csi2_csr_pkg::geom_state_e state_q;
  csi2_csr_pkg::geom_state_e state_nxt;

  logic [`STAT_CNT_W-1:0] ln_cnt_q;
  logic [`STAT_CNT_W-1:0] px_cnt_q;
  logic [`STAT_CNT_W-1:0] px_cnt_nxt;
  logic [`STAT_CNT_W-1:0] ln_done_q;
  logic [`STAT_CNT_W-1:0] px_done_q;
  logic                   ln_done_vld_q;
  logic                   px_done_vld_q;
  logic                   frame_done;
  logic                   line_done;

  logic [`STAT_CNT_W-1:0] max_ln_q;
  logic [`STAT_CNT_W-1:0] min_ln_q;
  logic [`STAT_CNT_W-1:0] max_px_q;
  logic [`STAT_CNT_W-1:0] min_px_q;
  logic                   px_rec_q;

  // A pixel on the line_end cycle still belongs to the line.
  assign px_cnt_nxt = px_cnt_q + `STAT_CNT_W'(frame_evt_i.px_valid);

  assign frame_done = (state_q == csi2_csr_pkg::IN_FRAME) && frame_evt_i.frame_end;
  assign line_done  = (state_q == csi2_csr_pkg::IN_LINE) && frame_evt_i.line_end;

  always_comb
    begin
      state_nxt = state_q;
      case (state_q)
        csi2_csr_pkg::IDLE:
          if (frame_evt_i.frame_start)
            state_nxt = csi2_csr_pkg::IN_FRAME;
        csi2_csr_pkg::IN_FRAME:
          if (frame_evt_i.frame_end)
            state_nxt = csi2_csr_pkg::IDLE;
          else if (frame_evt_i.line_start)
            state_nxt = csi2_csr_pkg::IN_LINE;
        csi2_csr_pkg::IN_LINE:
          if (frame_evt_i.line_end)
            state_nxt = csi2_csr_pkg::IN_FRAME;
        default:
          state_nxt = csi2_csr_pkg::IDLE;
      endcase
    end

  // Running counts and finished values.
  always_ff @(posedge clk_i)
    begin
      if ((state_q == csi2_csr_pkg::IDLE) && frame_evt_i.frame_start)
        ln_cnt_q <= '0;
      else if (line_done)
        ln_cnt_q <= ln_cnt_q + 1'b1;

      if (state_q == csi2_csr_pkg::IN_LINE)
        px_cnt_q <= px_cnt_nxt;
      else
        px_cnt_q <= '0; // Ready for the next line_start.

      if (frame_done)
        ln_done_q <= ln_cnt_q;
      if (line_done)
        px_done_q <= px_cnt_nxt;
    end

  always_ff @(posedge clk_i, posedge srst_i)
    if (srst_i)
      begin
        state_q       <= csi2_csr_pkg::IDLE;
        ln_done_vld_q <= 1'b0;
        px_done_vld_q <= 1'b0;
        max_ln_q      <= '0;
        min_ln_q      <= '1;
        max_px_q      <= '0;
        min_px_q      <= '1;
        px_rec_q      <= 1'b0;
      end
    else
      begin
        state_q       <= state_nxt;
        ln_done_vld_q <= frame_done;
        px_done_vld_q <= line_done;
        if (clear_stat_i)
          begin
            max_ln_q <= '0;
            min_ln_q <= '1;
            max_px_q <= '0;
            min_px_q <= '1;
            px_rec_q <= 1'b0;
          end
        else
          begin
            // Fold one cycle after the end marker.
            if (ln_done_vld_q && (ln_done_q > max_ln_q))
              max_ln_q <= ln_done_q;
            if (ln_done_vld_q && (ln_done_q < min_ln_q))
              min_ln_q <= ln_done_q;
            if (px_done_vld_q && (px_done_q > max_px_q))
              max_px_q <= px_done_q;
            if (px_done_vld_q && (px_done_q < min_px_q))
              min_px_q <= px_done_q;
            if (px_done_vld_q)
              px_rec_q <= 1'b1;
          end
      end

  assign geom_stats_o.max_ln = max_ln_q;
  assign geom_stats_o.min_ln = min_ln_q;
  assign geom_stats_o.max_px = max_px_q;
  assign geom_stats_o.min_px = min_px_q;

  a_px_order: assert property (
    @(posedge clk_i) disable iff (srst_i)
    px_rec_q |-> (min_px_q <= max_px_q)
  )
    else $error("pixel minimum above maximum");

endmodule

// File: verilog/csi2_stat_top.sv
`timescale 1ns/1ps

module csi2_stat_top (
  input                            clk_i,
  input                            srst_i,
  input  csi2_csr_pkg::axil_req_t  axil_req_i,
  output csi2_csr_pkg::axil_rsp_t  axil_rsp_o,
  input  csi2_csr_pkg::pkt_evt_t   pkt_evt_i,
  input  csi2_csr_pkg::frame_evt_t frame_evt_i,
  output logic                     phy_en_o,
  output logic [6:0]               sccb_slave_addr_o,
  output logic [4:0]               lane_0_delay_o,
  output logic [4:0]               lane_1_delay_o,
  output logic                     delay_act_o
);

  csi2_csr_pkg::err_stats_t  err_stats;
  csi2_csr_pkg::geom_stats_t geom_stats;
  logic                      clear_stat;

  csi2_err_counter csi2_err_counter_i (
    .clk_i        (clk_i),
    .srst_i       (srst_i),
    .clear_stat_i (clear_stat),
    .pkt_evt_i    (pkt_evt_i),
    .err_stats_o  (err_stats)
  );

  csi2_geom_tracker csi2_geom_tracker_i (
    .clk_i        (clk_i),
    .srst_i       (srst_i),
    .clear_stat_i (clear_stat),
    .frame_evt_i  (frame_evt_i),
    .geom_stats_o (geom_stats)
  );

  csi2_csr csi2_csr_i (
    .clk_i             (clk_i),
    .srst_i            (srst_i),
    .axil_req_i        (axil_req_i),
    .axil_rsp_o        (axil_rsp_o),
    .err_stats_i       (err_stats),
    .geom_stats_i      (geom_stats),
    .clear_stat_o      (clear_stat),
    .phy_en_o          (phy_en_o),
    .sccb_slave_addr_o (sccb_slave_addr_o),
    .lane_0_delay_o    (lane_0_delay_o),
    .lane_1_delay_o    (lane_1_delay_o),
    .delay_act_o       (delay_act_o)
  );

endmodule
